/* hdl/mipsDecodePkg.sv */
package mipsDecodePkg;

    localparam int instrWidth = 32;
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31; // ra

    // ----------------------------------------
    // instruction encodings
    // ----------------------------------------
    typedef enum logic [5:0] {
        opSpecial = 6'd0,  opRegimm = 6'd1, opJ = 6'd2,       opJal = 6'd3,
        opBeq = 6'd4,      opBne = 6'd5,    opBlez = 6'd6,    opBgtz = 6'd7,
        opAddi = 6'd8,     opAddiu = 6'd9,  opSlti = 6'd10,   opSltiu = 6'd11,
        opAndi = 6'd12,    opOri = 6'd13,   opXori = 6'd14,   opLui = 6'd15,
        opBeql = 6'd20,    opBnel = 6'd21,  opBlezl = 6'd22,  opBgtzl = 6'd23,
        opLb = 6'd32,      opLh = 6'd33,    opLw = 6'd35,     opLbu = 6'd36,
        opLhu = 6'd37,     opSb = 6'd40,    opSh = 6'd41,     opSw = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll = 6'd0,      fnSrl = 6'd2,    fnSra = 6'd3,     fnSllv = 6'd4,
        fnSrlv = 6'd6,     fnSrav = 6'd7,   fnJr = 6'd8,      fnJalr = 6'd9,
        fnSyscall = 6'd12, fnBreak = 6'd13, fnAdd = 6'd32,    fnAddu = 6'd33,
        fnSub = 6'd34,     fnSubu = 6'd35,  fnAnd = 6'd36,    fnOr = 6'd37,
        fnXor = 6'd38,     fnNor = 6'd39,   fnSlt = 6'd42,    fnSltu = 6'd43,
        fnTge = 6'd48,     fnTgeu = 6'd49,  fnTlt = 6'd50,    fnTltu = 6'd51,
        fnTeq = 6'd52,     fnTne = 6'd54
    } functT;

    // rt field under regimm
    typedef enum logic [4:0] {
        riBltz = 5'd0,     riBgez = 5'd1,   riBltzl = 5'd2,   riBgezl = 5'd3,
        riTgei = 5'd8,     riTgeiu = 5'd9,  riTlti = 5'd10,   riTltiu = 5'd11,
        riTeqi = 5'd12,    riTnei = 5'd14,  riBltzal = 5'd16, riBgezal = 5'd17,
        riBltzall = 5'd18, riBgezall = 5'd19
    } regimmT;

    // ----------------------------------------
    // control codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor, aluSll, aluSrl,
        aluSra, aluSlt, aluSltu, aluSeq, aluSne, aluSge, aluSgeu
    } aluOpT;

    typedef enum logic [2:0] {
        cmpNone, cmpEq, cmpNe, cmpLtz, cmpLez, cmpGtz, cmpGez
    } cmpOpT;

    typedef enum logic [1:0] {writeNone, writeAlu, writeMem, writePc} writeSourceT;

    typedef enum logic [1:0] {widthByte, widthHalf, widthWord} memWidthT;

    typedef enum logic [1:0] {excNone, excSyscall, excBreak, excUnknown} exceptionT;

    // ----------------------------------------
    // field extraction
    // ----------------------------------------
    function automatic logic [regAddrWidth-1:0] rsField(input logic [instrWidth-1:0] instr);
        return instr[25:21];
    endfunction

    function automatic logic [regAddrWidth-1:0] rtField(input logic [instrWidth-1:0] instr);
        return instr[20:16];
    endfunction

    function automatic logic [regAddrWidth-1:0] rdField(input logic [instrWidth-1:0] instr);
        return instr[15:11];
    endfunction

    function automatic logic [dataWidth-1:0] signImm(input logic [instrWidth-1:0] instr);
        return dataWidth'($signed(instr[15:0]));
    endfunction

endpackage

/* hdl/aluDecoder.sv */
`timescale 1ns/1ns

module aluDecoder (
    input  logic [mipsDecodePkg::instrWidth-1:0]   instruction,
    output logic                                   hit,
    output mipsDecodePkg::aluOpT                   aluOp,
    output logic                                   aluSrc,
    output logic [mipsDecodePkg::dataWidth-1:0]    immediate,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead1,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead2,
    output logic [mipsDecodePkg::regAddrWidth-1:0] destReg,
    output mipsDecodePkg::writeSourceT             writeSource,
    output logic                                   checkOverflow
);
    import mipsDecodePkg::*;

    logic isSpecial;
    logic shiftImm;
    logic shiftVar;

    assign isSpecial = opcodeT'(instruction[31:26]) == opSpecial;
    assign shiftImm = isSpecial && instruction[5:2] == 4'b0000; // sll, srl, sra
    assign shiftVar = isSpecial && instruction[5:2] == 4'b0001; // sllv, srlv, srav

    always_comb begin
        hit = 1'b1;
        aluOp = aluAdd;
        checkOverflow = 1'b0;
        if (isSpecial) begin
            case (functT'(instruction[5:0]))
                fnAdd: checkOverflow = 1'b1;
                fnAddu: aluOp = aluAdd;
                fnSub: begin
                    aluOp = aluSub;
                    checkOverflow = 1'b1;
                end
                fnSubu: aluOp = aluSub;
                fnAnd: aluOp = aluAnd;
                fnOr: aluOp = aluOr;
                fnXor: aluOp = aluXor;
                fnNor: aluOp = aluNor;
                fnSll, fnSllv: aluOp = aluSll;
                fnSrl, fnSrlv: aluOp = aluSrl;
                fnSra, fnSrav: aluOp = aluSra;
                fnSlt: aluOp = aluSlt;
                fnSltu: aluOp = aluSltu;
                default: hit = 1'b0;
            endcase
        end else begin
            case (opcodeT'(instruction[31:26]))
                opAddi: checkOverflow = 1'b1;
                opAddiu, opLui: aluOp = aluAdd; // lui adds the shifted half to r0
                opSlti: aluOp = aluSlt;
                opSltiu: aluOp = aluSltu;
                opAndi: aluOp = aluAnd;
                opOri: aluOp = aluOr;
                opXori: aluOp = aluXor;
                default: hit = 1'b0;
            endcase
        end
    end

    always_comb begin
        aluSrc = 1'b0;
        immediate = '0;
        regRead1 = '0;
        regRead2 = '0;
        destReg = '0;
        if (hit && !isSpecial) begin
            aluSrc = 1'b1;
            regRead1 = rsField(instruction);
            destReg = rtField(instruction);
            case (opcodeT'(instruction[31:26]))
                opAndi, opOri, opXori: immediate = dataWidth'(instruction[15:0]);
                opLui: immediate = {instruction[15:0], 16'b0};
                default: immediate = signImm(instruction);
            endcase
        end else if (hit && shiftImm) begin
            aluSrc = 1'b1;
            regRead1 = rtField(instruction);
            destReg = rdField(instruction);
            immediate = dataWidth'(instruction[10:6]); // shamt
        end else if (hit) begin
            regRead1 = shiftVar ? rtField(instruction) : rsField(instruction);
            regRead2 = shiftVar ? rsField(instruction) : rtField(instruction);
            destReg = rdField(instruction);
        end
    end

    assign writeSource = hit ? writeAlu : writeNone;

endmodule

/* hdl/memDecoder.sv */
`timescale 1ns/1ns

module memDecoder (
    input  logic [mipsDecodePkg::instrWidth-1:0]   instruction,
    output logic                                   hit,
    output logic                                   memLoad,
    output logic                                   memStore,
    output mipsDecodePkg::memWidthT                memWidth,
    output logic                                   memSignExtend,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead1,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead2,
    output logic [mipsDecodePkg::regAddrWidth-1:0] destReg,
    output logic [mipsDecodePkg::dataWidth-1:0]    immediate
);
    import mipsDecodePkg::*;

    always_comb begin
        hit = 1'b1;
        memLoad = 1'b0;
        memStore = 1'b0;
        memWidth = widthByte;
        memSignExtend = 1'b0;
        case (opcodeT'(instruction[31:26]))
            opLb: begin
                memLoad = 1'b1;
                memSignExtend = 1'b1;
            end
            opLbu: memLoad = 1'b1;
            opLh: begin
                memLoad = 1'b1;
                memWidth = widthHalf;
                memSignExtend = 1'b1;
            end
            opLhu: begin
                memLoad = 1'b1;
                memWidth = widthHalf;
            end
            opLw: begin
                memLoad = 1'b1;
                memWidth = widthWord;
            end
            opSb: memStore = 1'b1;
            opSh: begin
                memStore = 1'b1;
                memWidth = widthHalf;
            end
            opSw: begin
                memStore = 1'b1;
                memWidth = widthWord;
            end
            default: hit = 1'b0;
        endcase
    end

    // base in rs, offset forms the address
    assign regRead1 = hit ? rsField(instruction) : '0;
    assign regRead2 = memStore ? rtField(instruction) : '0; // store data
    assign destReg = memLoad ? rtField(instruction) : '0;
    assign immediate = hit ? signImm(instruction) : '0;

    assert property (@(instruction) !(memLoad && memStore))
        else $error("memDecoder: load and store decoded together");

endmodule

/* hdl/flowDecoder.sv */
`timescale 1ns/1ns

module flowDecoder (
    input  logic [mipsDecodePkg::instrWidth-1:0]   instruction,
    output logic                                   hit,
    output logic                                   branch,
    output logic                                   branchLikely,
    output mipsDecodePkg::cmpOpT                   cmpOp,
    output logic                                   jump,
    output logic                                   jumpFromReg,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead1,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead2,
    output logic [mipsDecodePkg::regAddrWidth-1:0] destReg,
    output mipsDecodePkg::writeSourceT             writeSource,
    output logic [mipsDecodePkg::dataWidth-1:0]    immediate
);
    import mipsDecodePkg::*;

    logic isRegimm;
    logic link;   // pc goes to a register
    logic linkRd; // jalr picks rd instead of ra

    assign isRegimm = opcodeT'(instruction[31:26]) == opRegimm;

    always_comb begin
        hit = 1'b1;
        cmpOp = cmpNone;
        jump = 1'b0;
        jumpFromReg = 1'b0;
        link = 1'b0;
        linkRd = 1'b0;
        case (opcodeT'(instruction[31:26]))
            opBeq, opBeql: cmpOp = cmpEq;
            opBne, opBnel: cmpOp = cmpNe;
            opBlez, opBlezl: cmpOp = cmpLez;
            opBgtz, opBgtzl: cmpOp = cmpGtz;
            opJ: jump = 1'b1;
            opJal: begin
                jump = 1'b1;
                link = 1'b1;
            end
            opRegimm: begin
                case (regimmT'(instruction[20:16]))
                    riBltz, riBltzl: cmpOp = cmpLtz;
                    riBgez, riBgezl: cmpOp = cmpGez;
                    riBltzal, riBltzall: begin
                        cmpOp = cmpLtz;
                        link = 1'b1;
                    end
                    riBgezal, riBgezall: begin
                        cmpOp = cmpGez;
                        link = 1'b1;
                    end
                    default: hit = 1'b0;
                endcase
            end
            opSpecial: begin
                case (functT'(instruction[5:0]))
                    fnJr: begin
                        jump = 1'b1;
                        jumpFromReg = 1'b1;
                    end
                    fnJalr: begin
                        jump = 1'b1;
                        jumpFromReg = 1'b1;
                        link = 1'b1;
                        linkRd = 1'b1;
                    end
                    default: hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;
        endcase
    end

    assign branch = cmpOp != cmpNone;
    // likely: opcode bit 4, or rt bit 1 under regimm
    assign branchLikely = branch && (isRegimm ? instruction[17] : instruction[30]);

    always_comb begin
        regRead1 = '0;
        regRead2 = '0;
        destReg = '0;
        writeSource = writeNone;
        immediate = '0;
        if (branch || jumpFromReg)
            regRead1 = rsField(instruction);
        if (cmpOp == cmpEq || cmpOp == cmpNe)
            regRead2 = rtField(instruction);
        if (branch)
            immediate = signImm(instruction);
        else if (jump && !jumpFromReg)
            immediate = dataWidth'(instruction[25:0]); // j/jal target
        if (link) begin
            writeSource = writePc;
            destReg = linkRd ? rdField(instruction) : linkReg;
        end
    end

endmodule

/* hdl/exceptionDecoder.sv */
`timescale 1ns/1ns

module exceptionDecoder (
    input  logic [mipsDecodePkg::instrWidth-1:0]   instruction,
    output logic                                   hit,
    output logic                                   trap,
    output mipsDecodePkg::aluOpT                   aluOp,
    output logic                                   aluSrc,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead1,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead2,
    output logic [mipsDecodePkg::dataWidth-1:0]    immediate,
    output mipsDecodePkg::exceptionT               exception
);
    import mipsDecodePkg::*;

    logic [2:0] trapCond;

    always_comb begin
        hit = 1'b1;
        trap = 1'b0;
        aluSrc = 1'b0;
        exception = excNone;
        case (opcodeT'(instruction[31:26]))
            opSpecial: begin
                case (functT'(instruction[5:0]))
                    fnSyscall: exception = excSyscall;
                    fnBreak: exception = excBreak;
                    fnTeq, fnTne, fnTge, fnTgeu, fnTlt, fnTltu: trap = 1'b1;
                    default: hit = 1'b0;
                endcase
            end
            opRegimm: begin
                case (regimmT'(instruction[20:16]))
                    riTeqi, riTnei, riTgei, riTgeiu, riTlti, riTltiu: begin
                        trap = 1'b1;
                        aluSrc = 1'b1;
                    end
                    default: hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;
        endcase
    end

    // both trap groups keep the compare in the low three code bits
    assign trapCond = aluSrc ? instruction[18:16] : instruction[2:0];

    always_comb begin
        aluOp = aluAdd;
        if (trap) begin
            case (trapCond)
                3'b000: aluOp = aluSge;
                3'b001: aluOp = aluSgeu;
                3'b010: aluOp = aluSlt;
                3'b011: aluOp = aluSltu;
                3'b100: aluOp = aluSeq;
                default: aluOp = aluSne;
            endcase
        end
    end

    assign regRead1 = trap ? rsField(instruction) : '0;
    assign regRead2 = (trap && !aluSrc) ? rtField(instruction) : '0;
    assign immediate = (trap && aluSrc) ? signImm(instruction) : '0;

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage #(
    parameter bit implementLikely = 1'b1
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [mipsDecodePkg::instrWidth-1:0]   instruction,
    input  logic                                   bubble,
    input  logic                                   stall,
    output mipsDecodePkg::aluOpT                   aluOp,
    output logic                                   aluSrc,
    output logic [mipsDecodePkg::dataWidth-1:0]    immediate,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead1,
    output logic [mipsDecodePkg::regAddrWidth-1:0] regRead2,
    output logic [mipsDecodePkg::regAddrWidth-1:0] destReg,
    output mipsDecodePkg::writeSourceT             writeSource,
    output logic                                   checkOverflow,
    output logic                                   memLoad,
    output logic                                   memStore,
    output mipsDecodePkg::memWidthT                memWidth,
    output logic                                   memSignExtend,
    output logic                                   branch,
    output logic                                   branchLikely,
    output mipsDecodePkg::cmpOpT                   cmpOp,
    output logic                                   jump,
    output logic                                   jumpFromReg,
    output logic                                   trap,
    output mipsDecodePkg::exceptionT               exception
);
    import mipsDecodePkg::*;

    logic hitAlu, hitMem, hitFlow, hitExc;
    aluOpT opAlu, opExc;
    logic srcAlu, srcExc;
    logic [dataWidth-1:0] immAlu, immMem, immFlow, immExc;
    logic [regAddrWidth-1:0] rd1Alu, rd1Mem, rd1Flow, rd1Exc;
    logic [regAddrWidth-1:0] rd2Alu, rd2Mem, rd2Flow, rd2Exc;
    logic [regAddrWidth-1:0] dstAlu, dstMem, dstFlow;
    writeSourceT wrSrcAlu, wrSrcFlow;
    logic overflowAlu;
    logic memLoadD, memStoreD, memSignD;
    memWidthT memWidthD;
    logic branchD, likelyD, jumpD, jumpRegD;
    cmpOpT cmpOpD;
    logic trapD;
    exceptionT excD;
    logic unknown;

    // ----------------------------------------
    // class decoders
    // ----------------------------------------
    aluDecoder i_aluDecoder (
        .instruction(instruction), .hit(hitAlu), .aluOp(opAlu), .aluSrc(srcAlu),
        .immediate(immAlu), .regRead1(rd1Alu), .regRead2(rd2Alu), .destReg(dstAlu),
        .writeSource(wrSrcAlu), .checkOverflow(overflowAlu)
    );

    memDecoder i_memDecoder (
        .instruction(instruction), .hit(hitMem), .memLoad(memLoadD), .memStore(memStoreD),
        .memWidth(memWidthD), .memSignExtend(memSignD), .regRead1(rd1Mem),
        .regRead2(rd2Mem), .destReg(dstMem), .immediate(immMem)
    );

    flowDecoder i_flowDecoder (
        .instruction(instruction), .hit(hitFlow), .branch(branchD), .branchLikely(likelyD),
        .cmpOp(cmpOpD), .jump(jumpD), .jumpFromReg(jumpRegD), .regRead1(rd1Flow),
        .regRead2(rd2Flow), .destReg(dstFlow), .writeSource(wrSrcFlow), .immediate(immFlow)
    );

    exceptionDecoder i_exceptionDecoder (
        .instruction(instruction), .hit(hitExc), .trap(trapD), .aluOp(opExc),
        .aluSrc(srcExc), .regRead1(rd1Exc), .regRead2(rd2Exc), .immediate(immExc),
        .exception(excD)
    );

    assign unknown = !(hitAlu || hitMem || hitFlow || hitExc) || (likelyD && !implementLikely);

    // ----------------------------------------
    // pipeline register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || (bubble && !stall)) begin // no-op pattern
            aluOp <= aluAdd;
            aluSrc <= 1'b0;
            immediate <= '0;
            regRead1 <= '0;
            regRead2 <= '0;
            destReg <= '0;
            writeSource <= writeNone;
            checkOverflow <= 1'b0;
            memLoad <= 1'b0;
            memStore <= 1'b0;
            memWidth <= widthByte;
            memSignExtend <= 1'b0;
            branch <= 1'b0;
            branchLikely <= 1'b0;
            cmpOp <= cmpNone;
            jump <= 1'b0;
            jumpFromReg <= 1'b0;
            trap <= 1'b0;
            exception <= excNone;
        end else if (!stall) begin // fields of missing classes are zero
            aluOp <= aluOpT'(opAlu | opExc);
            aluSrc <= srcAlu | srcExc;
            immediate <= immAlu | immMem | immFlow | immExc;
            regRead1 <= rd1Alu | rd1Mem | rd1Flow | rd1Exc;
            regRead2 <= rd2Alu | rd2Mem | rd2Flow | rd2Exc;
            destReg <= dstAlu | dstMem | dstFlow;
            writeSource <= writeSourceT'(wrSrcAlu | wrSrcFlow | (memLoadD ? writeMem : writeNone));
            checkOverflow <= overflowAlu;
            memLoad <= memLoadD;
            memStore <= memStoreD;
            memWidth <= memWidthD;
            memSignExtend <= memSignD;
            branch <= branchD;
            branchLikely <= likelyD;
            cmpOp <= cmpOpD;
            jump <= jumpD;
            jumpFromReg <= jumpRegD;
            trap <= trapD;
            exception <= unknown ? excUnknown : excD;
        end
    end

    // each encoding belongs to a single class decoder
    assert property (@(posedge clk) disable iff (rst) $onehot0({hitAlu, hitMem, hitFlow, hitExc}))
        else $error("decodeStage: more than one class decoder hit");

endmodule

/* tb/decodeStageTb.sv */
`timescale 1ns/1ns

module decodeStageTb;
    import mipsDecodePkg::*;

    localparam int maxLines = 200; // read loop limit
    localparam int resetCycles = 8;

    logic clk;
    logic rst;
    logic [instrWidth-1:0] instruction;
    logic bubble;
    logic stall;
    aluOpT aluOp;
    logic aluSrc;
    logic [dataWidth-1:0] immediate;
    logic [regAddrWidth-1:0] regRead1;
    logic [regAddrWidth-1:0] regRead2;
    logic [regAddrWidth-1:0] destReg;
    writeSourceT writeSource;
    logic checkOverflow;
    logic memLoad;
    logic memStore;
    memWidthT memWidth;
    logic memSignExtend;
    logic branch;
    logic branchLikely;
    cmpOpT cmpOp;
    logic jump;
    logic jumpFromReg;
    logic trap;
    exceptionT exception;

    int fd;
    int errorCount;
    int vectorCount;
    int lineCount;
    int fieldCount;
    logic vecFailed;
    logic readDone;
    string vecLabel;
    string lineBuf;
    logic [8*16-1:0] vecName;

    // one pattern line
    logic [31:0] instrV;
    logic bubbleV;
    logic stallV;
    logic [3:0] expAluOp;
    logic [31:0] expImm;
    logic [4:0] expRd1;
    logic [4:0] expRd2;
    logic [4:0] expDst;
    logic [1:0] expWsrc;
    logic [1:0] expWidth;
    logic [2:0] expCmp;
    logic [1:0] expExc;
    logic [9:0] expFlags; // aluSrc ovf load store sext branch likely jump jumpReg trap

    decodeStage i_decodeStage (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // checking
    // ----------------------------------------
    task automatic setNopExpect();
        expAluOp = '0;
        expImm = '0;
        expRd1 = '0;
        expRd2 = '0;
        expDst = '0;
        expWsrc = '0;
        expWidth = '0;
        expCmp = '0;
        expExc = '0;
        expFlags = '0;
    endtask

    task automatic checkValue(input string field, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: vector %0d %0s, %0s got %h expected %h",
                     $time, vectorCount, vecLabel, field, got, exp);
            errorCount++;
            vecFailed = 1'b1;
        end
    endtask

    task automatic compareOutputs();
        checkValue("aluOp", 32'(aluOp), 32'(expAluOp));
        checkValue("immediate", immediate, expImm);
        checkValue("regRead1", 32'(regRead1), 32'(expRd1));
        checkValue("regRead2", 32'(regRead2), 32'(expRd2));
        checkValue("destReg", 32'(destReg), 32'(expDst));
        checkValue("writeSource", 32'(writeSource), 32'(expWsrc));
        checkValue("memWidth", 32'(memWidth), 32'(expWidth));
        checkValue("cmpOp", 32'(cmpOp), 32'(expCmp));
        checkValue("exception", 32'(exception), 32'(expExc));
        checkValue("aluSrc", 32'(aluSrc), 32'(expFlags[9]));
        checkValue("checkOverflow", 32'(checkOverflow), 32'(expFlags[8]));
        checkValue("memLoad", 32'(memLoad), 32'(expFlags[7]));
        checkValue("memStore", 32'(memStore), 32'(expFlags[6]));
        checkValue("memSignExtend", 32'(memSignExtend), 32'(expFlags[5]));
        checkValue("branch", 32'(branch), 32'(expFlags[4]));
        checkValue("branchLikely", 32'(branchLikely), 32'(expFlags[3]));
        checkValue("jump", 32'(jump), 32'(expFlags[2]));
        checkValue("jumpFromReg", 32'(jumpFromReg), 32'(expFlags[1]));
        checkValue("trap", 32'(trap), 32'(expFlags[0]));
    endtask

    task automatic reportVector();
        if (vecFailed)
            $display("vector %0d %0s: mismatch", vectorCount, vecLabel);
        else
            $display("vector %0d %0s: ok", vectorCount, vecLabel);
    endtask

    // result of inputs set 2 ns after an edge shows one edge later
    task automatic runVector();
        vectorCount++;
        vecFailed = 1'b0;
        vecLabel = $sformatf("%0s", vecName);
        instruction = instrV;
        bubble = bubbleV;
        stall = stallV;
        @(posedge clk);
        #2;
        compareOutputs();
        reportVector();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rst = 1'b1;
        bubble = 1'b0;
        stall = 1'b0;
        instruction = 32'h0022_1821; // live addu that reset must override
        errorCount = 0;
        vectorCount = 0;
        lineCount = 0;
        readDone = 1'b0;
        vecFailed = 1'b0;
        vecLabel = "reset";
        setNopExpect();
        fd = $fopen("tb/decodePatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tb/decodePatterns.txt");
            errorCount++;
        end else begin
            for (int i = 0; i < resetCycles; i++) begin
                @(posedge clk);
                #2;
                compareOutputs();
            end
            rst = 1'b0;
            reportVector();
            while (!readDone && lineCount < maxLines) begin
                if ($fgets(lineBuf, fd) == 0) begin
                    readDone = 1'b1;
                end else begin
                    lineCount++;
                    fieldCount = $sscanf(lineBuf,
                        "%h %b %b %h %h %d %d %d %d %d %d %d %b %s",
                        instrV, bubbleV, stallV, expAluOp, expImm, expRd1, expRd2, expDst,
                        expWsrc, expWidth, expCmp, expExc, expFlags, vecName);
                    if (fieldCount == 14) begin
                        runVector();
                    end else if (fieldCount > 0) begin // comment lines give 0
                        $display("pattern line %0d is malformed, only %0d of 14 fields read",
                                 lineCount, fieldCount);
                        errorCount++;
                    end
                end
            end
            if (!readDone) begin
                $display("pattern read stopped after %0d lines before the end of file",
                         maxLines);
                errorCount++;
            end
            if (vectorCount == 0) begin
                $display("the pattern file holds no vectors");
                errorCount++;
            end
            $fclose(fd);
        end
        $display("reset plus %0d vectors run, %0d errors", vectorCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* tb/decodePatterns.txt */
# instr bubble stall | aluOp imm rd1 rd2 dst wsrc width cmp exc flags name
# flags: aluSrc ovf load store sext branch likely jump jumpReg trap (decimal enum codes)
00221821 0 0 0 00000000  1  2  3 1 0 0 0 0000000000 addu
00a62022 0 0 1 00000000  5  6  4 1 0 0 0 0100000000 sub
35078001 0 0 3 00008001  8  0  7 1 0 0 0 1000000000 ori
2149fffc 0 0 0 fffffffc 10  0  9 1 0 0 0 1100000000 addi
298b7fff 0 0 9 00007fff 12  0 11 1 0 0 0 1000000000 slti
000e6940 0 0 6 00000005 14  0 13 1 0 0 0 1000000000 sll
02307807 0 0 8 00000000 16 17 15 1 0 0 0 0000000000 srav
3c121234 0 0 0 12340000  0  0 18 1 0 0 0 1000000000 lui
8062fff8 0 0 0 fffffff8  3  0  2 2 0 0 0 0010100000 lb
94a40006 0 0 0 00000006  5  0  4 2 1 0 0 0010000000 lhu
8ce60100 0 0 0 00000100  7  0  6 2 2 0 0 0010000000 lw
a128ffff 0 0 0 ffffffff  9  8  0 0 0 0 0 0001000000 sb
ad6a000c 0 0 0 0000000c 11 10  0 0 2 0 0 0001000000 sw
1022fffd 0 0 0 fffffffd  1  2  0 0 0 1 0 0000010000 beq
1c600010 0 0 0 00000010  3  0  0 0 0 5 0 0000010000 bgtz
04900020 0 0 0 00000020  4  0 31 3 0 3 0 0000010000 bltzal
54a60004 0 0 0 00000004  5  6  0 0 0 2 0 0000011000 bnel
08123456 0 0 0 00123456  0  0  0 0 0 0 0 0000000100 j
0fffffff 0 0 0 03ffffff  0  0 31 3 0 0 0 0000000100 jal
03e00008 0 0 0 00000000 31  0  0 0 0 0 0 0000000110 jr
01003809 0 0 0 00000000  8  0  7 3 0 0 0 0000000110 jalr
0000000c 0 0 0 00000000  0  0  0 0 0 0 1 0000000000 syscall
0000000d 0 0 0 00000000  0  0  0 0 0 0 2 0000000000 break
00220034 0 0 b 00000000  1  2  0 0 0 0 0 0000000001 teq
046b8000 0 0 a ffff8000  3  0  0 0 0 0 0 1000000001 tltiu
00220018 0 0 0 00000000  0  0  0 0 0 0 3 0000000000 mult
00001810 0 0 0 00000000  0  0  0 0 0 0 3 0000000000 mfhi
40846000 0 0 0 00000000  0  0  0 0 0 0 3 0000000000 mtc0
fc000000 0 0 0 00000000  0  0  0 0 0 0 3 0000000000 unusedOp
00221821 1 0 0 00000000  0  0  0 0 0 0 0 0000000000 bubble
00221821 0 0 0 00000000  1  2  3 1 0 0 0 0000000000 adduAgain
00a62022 0 1 0 00000000  1  2  3 1 0 0 0 0000000000 stallSub
8ce60100 1 1 0 00000000  1  2  3 1 0 0 0 0000000000 stallBubble
35078001 0 0 3 00008001  8  0  7 1 0 0 0 1000000000 oriAfterStall
00000000 1 0 0 00000000  0  0  0 0 0 0 0 0000000000 bubbleNop
2149fffc 0 1 0 00000000  0  0  0 0 0 0 0 0000000000 stallOnNop
2149fffc 0 0 0 fffffffc 10  0  9 1 0 0 0 1100000000 addiAfterStall
00000000 0 0 6 00000000  0  0  0 1 0 0 0 1000000000 sllZero

/* flist.f */
hdl/mipsDecodePkg.sv
hdl/aluDecoder.sv
hdl/memDecoder.sv
hdl/flowDecoder.sv
hdl/exceptionDecoder.sv
hdl/decodeStage.sv
tb/decodeStageTb.sv

/* run.sh */
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --top-module decodeStageTb -Mdir "$buildDir" -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$buildDir/VdecodeStageTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^test passed$" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1
